//--- hdl/link_pkg.sv
package link_pkg;

  // Stream byte width
  localparam int DATA_WIDTH = 8;

  // Packet FIFO storage
  localparam int FIFO_DEPTH = 32;
  localparam int ADDR_BITS = $clog2(FIFO_DEPTH);

  // Naks accepted for one frame before it is abandoned
  localparam int MAX_RETRIES = 3;

  // Event counter width
  localparam int CNT_WIDTH = 16;

  // APB register byte offsets
  localparam logic [7:0] REG_LEVEL = 8'h00;
  localparam logic [7:0] REG_GOOD = 8'h04;
  localparam logic [7:0] REG_BAD = 8'h08;
  localparam logic [7:0] REG_RETRY = 8'h0C;
  localparam logic [7:0] REG_ABANDON = 8'h10;
  localparam logic [7:0] REG_CLEAR = 8'h14;

endpackage

//--- hdl/axis_if.sv
`timescale 1ns/1ps

// Byte stream with valid/ready handshake and end-of-frame marker
interface axis_if;
  import link_pkg::*;

  logic valid;
  logic ready;
  logic last;
  logic [DATA_WIDTH-1:0] data;

  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

//--- hdl/frame_checker.sv
`timescale 1ns/1ps

module frame_checker (
  input  logic                           clock,
  input  logic                           reset,
  axis_if.sink                           in_s,
  axis_if.source                         out_s,
  output logic                           drop_o,
  input  logic                           clear_i,
  output logic [link_pkg::CNT_WIDTH-1:0] good_count_o,
  output logic [link_pkg::CNT_WIDTH-1:0] bad_count_o
);
  import link_pkg::*;

  logic [DATA_WIDTH-1:0] xor_q;
  logic [CNT_WIDTH-1:0]  good_q;
  logic [CNT_WIDTH-1:0]  bad_q;
  logic                  xfer;
  logic                  last_xfer;

  // Data path is a plain pass-through
  assign out_s.valid = in_s.valid;
  assign out_s.last  = in_s.last;
  assign out_s.data  = in_s.data;
  assign in_s.ready  = out_s.ready;

  assign xfer      = in_s.valid && out_s.ready;
  assign last_xfer = xfer && in_s.last;

  // Check byte must equal the XOR of everything before it
  assign drop_o = last_xfer && (in_s.data != xor_q);

  // Running XOR restarts after every last beat
  always_ff @(posedge clock) begin
    if (reset) begin
      xor_q <= '0;
    end else if (xfer) begin
      if (in_s.last) begin
        xor_q <= '0;
      end else begin
        xor_q <= xor_q ^ in_s.data;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      good_q <= '0;
      bad_q  <= '0;
    end else if (last_xfer) begin
      if (drop_o) begin
        bad_q <= bad_q + 1'b1;
      end else begin
        good_q <= good_q + 1'b1;
      end
    end
  end

  assign good_count_o = good_q;
  assign bad_count_o  = bad_q;

endmodule

//--- hdl/axis_skid.sv
`timescale 1ns/1ps

module axis_skid #(
  parameter bit BYPASS = 1'b0
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   flush_i,
  axis_if.sink   s_s,
  axis_if.source m_s
);
  import link_pkg::*;

  generate
    if (BYPASS) begin : g_bypass

      assign m_s.valid = s_s.valid;
      assign m_s.last  = s_s.last;
      assign m_s.data  = s_s.data;
      assign s_s.ready = m_s.ready;

    end else begin : g_skid

      logic                  out_valid_q;
      logic                  out_last_q;
      logic [DATA_WIDTH-1:0] out_data_q;
      logic                  skid_valid_q;
      logic                  skid_last_q;
      logic [DATA_WIDTH-1:0] skid_data_q;
      logic                  load;

      // Output register may take a new beat
      assign load = m_s.ready || !out_valid_q;

      // Ready comes only from registered state
      assign s_s.ready = !skid_valid_q;

      always_ff @(posedge clock) begin
        if (reset || flush_i) begin
          out_valid_q  <= 1'b0;
          skid_valid_q <= 1'b0;
        end else if (load) begin
          out_valid_q  <= skid_valid_q || s_s.valid;
          skid_valid_q <= 1'b0;
        end else if (s_s.valid && !skid_valid_q) begin
          skid_valid_q <= 1'b1;
        end
      end

      always_ff @(posedge clock) begin
        if (load) begin
          if (skid_valid_q) begin
            {out_last_q, out_data_q} <= {skid_last_q, skid_data_q};
          end else begin
            {out_last_q, out_data_q} <= {s_s.last, s_s.data};
          end
        end else if (s_s.valid && !skid_valid_q) begin
          {skid_last_q, skid_data_q} <= {s_s.last, s_s.data};
        end
      end

      assign m_s.valid = out_valid_q;
      assign m_s.last  = out_last_q;
      assign m_s.data  = out_data_q;

    end
  endgenerate

endmodule

//--- hdl/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo (
  input  logic                         clock,
  input  logic                         reset,
  axis_if.sink                         wr_s,
  axis_if.source                       rd_s,
  input  logic                         drop_i,
  input  logic                         redo_i,
  input  logic                         next_i,
  output logic [link_pkg::ADDR_BITS:0] level_o
);
  import link_pkg::*;

  // Each entry keeps the last bit above the data byte
  logic [DATA_WIDTH:0] sram [FIFO_DEPTH];

  // Write, commit, read and replay pointers, one bit wider than the index
  logic [ADDR_BITS:0] wptr_q;
  logic [ADDR_BITS:0] cptr_q;
  logic [ADDR_BITS:0] rptr_q;
  logic [ADDR_BITS:0] pptr_q;
  logic [ADDR_BITS:0] wptr_d;
  logic [ADDR_BITS:0] pptr_d;

  logic wready_q;
  logic store;
  logic commit;
  logic full;
  logic full_d;

  // Registered SRAM read stage
  logic                  x_valid_q;
  logic                  x_last_q;
  logic [DATA_WIDTH-1:0] x_data_q;
  logic                  hold_q;
  logic                  fetch;

  axis_if x_s ();

  // Write side
  assign wr_s.ready = wready_q;
  assign store      = wr_s.valid && wready_q;
  assign commit     = store && wr_s.last && !drop_i;

  // A dropped frame rolls back to the last commit
  assign wptr_d = drop_i ? cptr_q : (store ? wptr_q + 1'b1 : wptr_q);
  assign pptr_d = next_i ? rptr_q : pptr_q;

  // Space is only released once a frame has been acknowledged
  assign full   = (wptr_q - pptr_q) == (ADDR_BITS + 1)'(FIFO_DEPTH);
  assign full_d = (wptr_d - pptr_d) == (ADDR_BITS + 1)'(FIFO_DEPTH);

  always_ff @(posedge clock) begin
    if (store) begin
      sram[wptr_q[ADDR_BITS-1:0]] <= {wr_s.last, wr_s.data};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wptr_q   <= '0;
      cptr_q   <= '0;
      pptr_q   <= '0;
      wready_q <= 1'b0;
    end else begin
      wptr_q   <= wptr_d;
      pptr_q   <= pptr_d;
      wready_q <= !full_d;
      if (commit) begin
        cptr_q <= wptr_q + 1'b1;
      end
    end
  end

  assign level_o = wptr_q - pptr_q;

  // Read side stops after one frame's last beat until ack or nak resolves it
  assign fetch = !hold_q && !(x_valid_q && x_last_q) && (rptr_q != cptr_q)
                 && (!x_valid_q || x_s.ready) && !redo_i && !next_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      rptr_q    <= '0;
      x_valid_q <= 1'b0;
      hold_q    <= 1'b0;
    end else if (redo_i) begin
      rptr_q    <= pptr_q;
      x_valid_q <= 1'b0;
      hold_q    <= 1'b0;
    end else begin
      if (next_i) begin
        hold_q <= 1'b0;
      end else if (x_valid_q && x_last_q && x_s.ready) begin
        hold_q <= 1'b1;
      end

      if (fetch) begin
        rptr_q    <= rptr_q + 1'b1;
        x_valid_q <= 1'b1;
      end else if (x_valid_q && x_s.ready) begin
        x_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch) begin
      {x_last_q, x_data_q} <= sram[rptr_q[ADDR_BITS-1:0]];
    end
  end

  assign x_s.valid = x_valid_q;
  assign x_s.last  = x_last_q;
  assign x_s.data  = x_data_q;

  // Decouples the SRAM stage from output back-pressure
  axis_skid #(
    .BYPASS(1'b0)
  ) skid0 (
    .clock  (clock),
    .reset  (reset),
    .flush_i(redo_i),
    .s_s    (x_s),
    .m_s    (rd_s)
  );

  // Registered ready must already be low when the pointers reach full
  no_write_when_full: assert property (@(posedge clock) disable iff (reset)
    store |-> !full);

  redo_next_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(redo_i && next_i));

  // Rollback is only valid on a last beat that is being stored
  drop_on_last_store: assert property (@(posedge clock) disable iff (reset)
    drop_i |-> store && wr_s.last);

endmodule

//--- hdl/retry_control.sv
`timescale 1ns/1ps

module retry_control (
  input  logic                           clock,
  input  logic                           reset,
  axis_if.sink                           in_s,
  axis_if.source                         out_s,
  input  logic                           ack_i,
  input  logic                           nak_i,
  input  logic                           clear_i,
  output logic                           redo_o,
  output logic                           next_o,
  output logic [link_pkg::CNT_WIDTH-1:0] retry_count_o,
  output logic [link_pkg::CNT_WIDTH-1:0] abandon_count_o
);
  import link_pkg::*;

  logic                               wait_q;
  logic                               redo_q;
  logic                               next_q;
  logic [$clog2(MAX_RETRIES+1)-1:0]   nak_cnt_q;
  logic [CNT_WIDTH-1:0]               retry_q;
  logic [CNT_WIDTH-1:0]               abandon_q;
  logic                               last_xfer;
  logic                               ack_take;
  logic                               nak_take;
  logic                               give_up;

  // Stream is blocked in both directions while waiting for the far end
  assign out_s.valid = in_s.valid && !wait_q;
  assign out_s.last  = in_s.last;
  assign out_s.data  = in_s.data;
  assign in_s.ready  = out_s.ready && !wait_q;

  assign last_xfer = out_s.valid && out_s.ready && in_s.last;
  assign ack_take  = wait_q && ack_i;
  assign nak_take  = wait_q && nak_i && !ack_i;
  assign give_up   = nak_take && (int'(nak_cnt_q) == MAX_RETRIES - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_q    <= 1'b0;
      redo_q    <= 1'b0;
      next_q    <= 1'b0;
      nak_cnt_q <= '0;
    end else begin
      redo_q <= 1'b0;
      next_q <= 1'b0;
      if (last_xfer) begin
        wait_q <= 1'b1;
      end else if (ack_take) begin
        wait_q    <= 1'b0;
        next_q    <= 1'b1;
        nak_cnt_q <= '0;
      end else if (nak_take) begin
        wait_q <= 1'b0;
        if (give_up) begin
          // Frame is released as if acked
          next_q    <= 1'b1;
          nak_cnt_q <= '0;
        end else begin
          redo_q    <= 1'b1;
          nak_cnt_q <= nak_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      retry_q   <= '0;
      abandon_q <= '0;
    end else if (give_up) begin
      abandon_q <= abandon_q + 1'b1;
    end else if (nak_take) begin
      retry_q <= retry_q + 1'b1;
    end
  end

  assign redo_o          = redo_q;
  assign next_o          = next_q;
  assign retry_count_o   = retry_q;
  assign abandon_count_o = abandon_q;

  // Far end only replies to a frame that has been sent completely
  reply_only_when_waiting: assert property (@(posedge clock) disable iff (reset)
    (ack_i || nak_i) |-> wait_q);

endmodule

//--- hdl/link_apb_regs.sv
`timescale 1ns/1ps

module link_apb_regs (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [7:0]                     paddr_i,
  input  logic [31:0]                    pwdata_i,
  output logic [31:0]                    prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,
  input  logic [link_pkg::ADDR_BITS:0]   level_i,
  input  logic [link_pkg::CNT_WIDTH-1:0] good_i,
  input  logic [link_pkg::CNT_WIDTH-1:0] bad_i,
  input  logic [link_pkg::CNT_WIDTH-1:0] retry_i,
  input  logic [link_pkg::CNT_WIDTH-1:0] abandon_i,
  output logic                           clear_o
);
  import link_pkg::*;

  logic access;
  logic known;
  logic clear_q;

  // No wait states
  assign access   = psel_i && penable_i;
  assign pready_o = access;

  always_comb begin
    known    = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      REG_LEVEL:   prdata_o = 32'(level_i);
      REG_GOOD:    prdata_o = 32'(good_i);
      REG_BAD:     prdata_o = 32'(bad_i);
      REG_RETRY:   prdata_o = 32'(retry_i);
      REG_ABANDON: prdata_o = 32'(abandon_i);
      REG_CLEAR:   prdata_o = '0;
      default:     known = 1'b0;
    endcase
  end

  // Only the clear register accepts writes
  assign pslverr_o = access && (!known || (pwrite_i && paddr_i != REG_CLEAR));

  always_ff @(posedge clock) begin
    if (reset) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= access && pwrite_i && (paddr_i == REG_CLEAR);
    end
  end

  assign clear_o = clear_q;

  // Access phase always follows a setup phase
  apb_setup_first: assert property (@(posedge clock) disable iff (reset)
    access |-> $past(psel_i && !penable_i));

  apb_wdata_known: assert property (@(posedge clock) disable iff (reset)
    (access && pwrite_i) |-> !$isunknown(pwdata_i));

endmodule

//--- hdl/packet_link_buffer.sv
`timescale 1ns/1ps

module packet_link_buffer (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  logic                            in_last_i,
  input  logic [link_pkg::DATA_WIDTH-1:0] in_data_i,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output logic                            out_last_o,
  output logic [link_pkg::DATA_WIDTH-1:0] out_data_o,
  input  logic                            ack_i,
  input  logic                            nak_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [7:0]                      paddr_i,
  input  logic [31:0]                     pwdata_i,
  output logic [31:0]                     prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o
);
  import link_pkg::*;

  axis_if in_s ();
  axis_if chk_s ();
  axis_if fifo_s ();
  axis_if out_s ();

  logic                 drop;
  logic                 redo;
  logic                 next;
  logic                 clear_counters;
  logic [ADDR_BITS:0]   level;
  logic [CNT_WIDTH-1:0] good_count;
  logic [CNT_WIDTH-1:0] bad_count;
  logic [CNT_WIDTH-1:0] retry_count;
  logic [CNT_WIDTH-1:0] abandon_count;

  // Input port into the stream
  assign in_s.valid = in_valid_i;
  assign in_s.last  = in_last_i;
  assign in_s.data  = in_data_i;
  assign in_ready_o = in_s.ready;

  // Output stream onto the ports
  assign out_valid_o = out_s.valid;
  assign out_last_o  = out_s.last;
  assign out_data_o  = out_s.data;
  assign out_s.ready = out_ready_i;

  frame_checker checker0 (
    .clock       (clock),
    .reset       (reset),
    .in_s        (in_s),
    .out_s       (chk_s),
    .drop_o      (drop),
    .clear_i     (clear_counters),
    .good_count_o(good_count),
    .bad_count_o (bad_count)
  );

  packet_fifo fifo0 (
    .clock  (clock),
    .reset  (reset),
    .wr_s   (chk_s),
    .rd_s   (fifo_s),
    .drop_i (drop),
    .redo_i (redo),
    .next_i (next),
    .level_o(level)
  );

  retry_control retry0 (
    .clock          (clock),
    .reset          (reset),
    .in_s           (fifo_s),
    .out_s          (out_s),
    .ack_i          (ack_i),
    .nak_i          (nak_i),
    .clear_i        (clear_counters),
    .redo_o         (redo),
    .next_o         (next),
    .retry_count_o  (retry_count),
    .abandon_count_o(abandon_count)
  );

  link_apb_regs regs0 (
    .clock    (clock),
    .reset    (reset),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .level_i  (level),
    .good_i   (good_count),
    .bad_i    (bad_count),
    .retry_i  (retry_count),
    .abandon_i(abandon_count),
    .clear_o  (clear_counters)
  );

endmodule

//--- testbench/packet_link_buffer_tb.sv
`timescale 1ns/1ps

module packet_link_buffer_tb;
  import link_pkg::*;

  logic                  clock;
  logic                  reset;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic                  in_last_i;
  logic [DATA_WIDTH-1:0] in_data_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  out_last_o;
  logic [DATA_WIDTH-1:0] out_data_o;
  logic                  ack_i;
  logic                  nak_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [7:0]            paddr_i;
  logic [31:0]           pwdata_i;
  logic [31:0]           prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;

  // Frames and replies as read from the data file
  logic [DATA_WIDTH-1:0] frame_bytes[$];
  int                    frame_start[$];
  int                    frame_len[$];
  logic                  frame_good[$];
  logic [7:0]            reply_chr[$];
  int                    reply_start[$];
  int                    reply_num[$];
  // Level, good, bad, retry, abandon
  logic [CNT_WIDTH-1:0]  exp_regs[5];

  integer seed = 12;
  int     cycles = 0;
  int     cycle_limit = 500;
  logic   stall_en = 1'b0;
  logic   ready_seen = 1'b0;
  logic   saw_full = 1'b0;

  packet_link_buffer dut0 (
    .clock      (clock),
    .reset      (reset),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_last_i  (in_last_i),
    .in_data_i  (in_data_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_last_o (out_last_o),
    .out_data_o (out_data_o),
    .ack_i      (ack_i),
    .nak_i      (nak_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_byte(input string name, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error at %0t: %s expected %h, got %h",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error at %0t: %s expected %b, got %b",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_WIDTH-1:0] expected,
                             input logic [CNT_WIDTH-1:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error at %0t: %s expected %0d, got %0d",
                                  $time, name, expected, actual));
    end
  endtask

  // Records are "frame len bytes.. flag replies" and one closing "regs" record
  task automatic read_testdata();
    int                    fd;
    int                    code;
    int                    len;
    int                    good;
    int                    k;
    logic [63:0]           tag;
    logic [63:0]           script;
    logic [DATA_WIDTH-1:0] value;
    logic [7:0]            c;
    logic                  done;
    fd = $fopen("testbench/packet_link_testdata.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open testbench/packet_link_testdata.txt");
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        stop_with_failure("data file ended before its regs record");
      end else if (tag == "frame") begin
        code = $fscanf(fd, "%d", len);
        frame_start.push_back(frame_bytes.size());
        frame_len.push_back(len);
        for (int j = 0; j < len; j++) begin
          code = $fscanf(fd, "%h", value);
          frame_bytes.push_back(value);
        end
        code = $fscanf(fd, "%d %s", good, script);
        frame_good.push_back(good != 0);
        reply_start.push_back(reply_chr.size());
        k = 0;
        // Characters sit right-justified in the vector
        for (int i = 7; i >= 0; i--) begin
          c = script[i*8 +: 8];
          if (c == "A" || c == "N") begin
            reply_chr.push_back(c);
            k++;
          end
        end
        reply_num.push_back(k);
      end else if (tag == "regs") begin
        for (int i = 0; i < 5; i++) begin
          code = $fscanf(fd, "%d", exp_regs[i]);
        end
        done = 1'b1;
      end else begin
        stop_with_failure("unknown record in the data file");
      end
    end
    $fclose(fd);
  endtask

  // Every transmission of a good frame counts, a bad frame goes in once
  function automatic int total_bytes();
    int sum;
    sum = 0;
    foreach (frame_len[f]) begin
      if (frame_good[f]) begin
        sum += frame_len[f] * reply_num[f];
      end else begin
        sum += frame_len[f];
      end
    end
    return sum;
  endfunction

  task automatic send_frame(input int f);
    logic taken;
    for (int j = 0; j < frame_len[f]; j++) begin
      in_valid_i = 1'b1;
      in_data_i  = frame_bytes[frame_start[f] + j];
      in_last_i  = (j == frame_len[f] - 1);
      taken = 1'b0;
      // Ready is registered, so its value at the falling edge holds to the rising one
      while (!taken) begin
        @(negedge clock);
        taken = in_ready_o;
        @(posedge clock);
        #1;
      end
    end
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
  endtask

  task automatic drive_inputs();
    foreach (frame_len[f]) begin
      send_frame(f);
      if (f % 2 == 1) begin
        @(posedge clock);
        #1;
      end
    end
  endtask

  task automatic wait_output_beat(output logic [DATA_WIDTH-1:0] data, output logic last);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clock);
      taken = out_valid_o && out_ready_i;
    end
    data = out_data_o;
    last = out_last_o;
  endtask

  task automatic send_reply(input logic [7:0] c);
    repeat (2) begin
      @(negedge clock);
      if (out_valid_o) begin
        stop_with_failure("out_valid_o went high while the frame waited for a reply");
      end
    end
    @(posedge clock);
    #1;
    ack_i = (c == "A");
    nak_i = (c == "N");
    @(posedge clock);
    #1;
    ack_i = 1'b0;
    nak_i = 1'b0;
  endtask

  // Dropped frames are skipped, an abandoned frame is followed by the next one
  task automatic collect_outputs();
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
    foreach (frame_len[f]) begin
      if (frame_good[f]) begin
        for (int r = 0; r < reply_num[f]; r++) begin
          for (int j = 0; j < frame_len[f]; j++) begin
            wait_output_beat(data, last);
            check_byte("out_data_o", frame_bytes[frame_start[f] + j], data);
            check_last("out_last_o", j == frame_len[f] - 1, last);
          end
          send_reply(reply_chr[reply_start[f] + r]);
        end
      end
    end
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(posedge clock);
    #1;
    penable_i = 1'b1;
    @(negedge clock);
    check_last("pready_o", 1'b1, pready_o);
    data = prdata_o;
    err  = pslverr_o;
    @(posedge clock);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(posedge clock);
    #1;
    penable_i = 1'b1;
    @(negedge clock);
    check_last("pready_o", 1'b1, pready_o);
    err = pslverr_o;
    @(posedge clock);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic expect_register(input logic [7:0] addr, input string name,
                                 input logic [CNT_WIDTH-1:0] expected);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_last("pslverr_o", 1'b0, err);
    check_count(name, expected, data[CNT_WIDTH-1:0]);
  endtask

  // Random output stalls once reset is over
  initial begin
    out_ready_i = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      out_ready_i = stall_en ? (($random(seed) & 3) != 0) : 1'b0;
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      stop_with_failure("the run did not finish within the cycle limit");
    end
  end

  // Notes whether the FIFO ever pushed back on a waiting input beat
  always @(negedge clock) begin
    if (!reset && in_ready_o) begin
      ready_seen = 1'b1;
    end
    if (ready_seen && in_valid_i && !in_ready_o) begin
      saw_full = 1'b1;
    end
  end

  initial begin
    logic [31:0] rdata;
    logic        rerr;
    reset      = 1'b1;
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
    in_data_i  = '0;
    ack_i      = 1'b0;
    nak_i      = 1'b0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    read_testdata();
    cycle_limit = 40 * total_bytes() + 500;

    repeat (3) @(posedge clock);
    @(negedge clock);
    check_last("in_ready_o", 1'b0, in_ready_o);
    check_last("out_valid_o", 1'b0, out_valid_o);
    check_last("pready_o", 1'b0, pready_o);
    @(posedge clock);
    #1;
    reset    = 1'b0;
    stall_en = 1'b1;

    fork
      drive_inputs();
      collect_outputs();
    join

    // Let the final next pulse release the last frame
    repeat (4) @(posedge clock);
    #1;
    expect_register(REG_LEVEL, "level", exp_regs[0]);
    expect_register(REG_GOOD, "good_count", exp_regs[1]);
    expect_register(REG_BAD, "bad_count", exp_regs[2]);
    expect_register(REG_RETRY, "retry_count", exp_regs[3]);
    expect_register(REG_ABANDON, "abandon_count", exp_regs[4]);

    apb_write(REG_CLEAR, 32'h1, rerr);
    check_last("pslverr_o", 1'b0, rerr);
    expect_register(REG_GOOD, "good_count", '0);
    expect_register(REG_BAD, "bad_count", '0);
    expect_register(REG_RETRY, "retry_count", '0);
    expect_register(REG_ABANDON, "abandon_count", '0);

    // Offset past the last register, and a write to a read-only one
    apb_read(REG_CLEAR + 8'h04, rdata, rerr);
    check_last("pslverr_o", 1'b1, rerr);
    apb_write(REG_GOOD, 32'h0, rerr);
    check_last("pslverr_o", 1'b1, rerr);

    if (!saw_full) begin
      stop_with_failure("in_ready_o never dropped, so the FIFO was never filled");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- testbench/packet_link_testdata.txt
frame 5 01 02 03 04 04 1 A
frame 8 10 20 30 40 50 60 70 00 1 NA
frame 6 aa bb cc dd ee 5e 0 -
frame 12 00 01 02 03 04 05 06 07 08 09 0a 0b 1 NNN
frame 10 ff fe fd fc fb fa f9 f8 f7 f7 1 A
frame 4 55 aa 00 00 0 -
frame 14 3c 5a 96 e1 07 42 81 18 24 99 c3 66 0f da 1 NNA
frame 2 7e 7e 1 A
frame 9 11 22 44 88 12 34 56 78 f7 1 NA
frame 7 de ad be ef 01 02 21 1 A
frame 3 01 02 00 0 -
frame 1 00 1 A
regs 0 9 3 6 1

//--- packet_link_buffer.f
hdl/link_pkg.sv
hdl/axis_if.sv
hdl/frame_checker.sv
hdl/axis_skid.sv
hdl/packet_fifo.sv
hdl/retry_control.sv
hdl/link_apb_regs.sv
hdl/packet_link_buffer.sv
testbench/packet_link_buffer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the packet link buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=packet_link_buffer_tb
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f packet_link_buffer.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
